// ==== Bender.yml ====
package:
  name: lwc_api

sources:
  - hdl/lwc_pkg.sv
  - hdl/core_pkg.sv
  - hdl/round_counter.sv
  - hdl/segment_tracker.sv
  - hdl/pdo_formatter.sv
  - hdl/api_ctrl.sv
  - hdl/lwc_api_top.sv
  - target: test
    files:
      - bench/tb_lwc_api.sv

// ==== bench/tb_lwc_api.sv ====
`timescale 1ns/100ps

module tb_lwc_api;
   import lwc_pkg::*;
   import core_pkg::*;

   localparam int        HALF        = 10;             // 20 ns clock
   localparam rc_t       RC_LAST     = RC_LAST_DEFAULT;
   localparam lwc_word_t CORE_MASK   = 32'h5A3C_96E0;  // lsb clear so bad tag words stay nonzero
   localparam int        NUM_RUNS    = 18;             // core runs over all tests
   localparam int        NUM_TESTS   = 5;
   localparam int        BLOCK_SLACK = 64;             // four words with gaps and stalls
   localparam int        TEST_SLACK  = 100;            // headers and status

   typedef struct packed {
      lwc_word_t  word;
      logic       last;
      byte_mask_t mask;
   } pdo_exp_t;

   logic       clk, rst, pdi_valid, pdi_ready, pdo_valid, pdo_ready, pdo_last;
   lwc_word_t  pdi, pdo, core_din, core_dout;
   core_ctrl_t core_ctrl;
   logic       zero_tag, stall_on, in_run;
   pdo_exp_t   exp_q[$];
   pdo_exp_t   got_exp;
   lwc_word_t  ad_w[$], msg_w[$], nonce_w[$], load_q[$], nonce_q[$];
   domain_t    dom_q[$], dom_exp[$];
   rc_t        exp_rc;
   int         rounds, run_len, seed, timeout_limit;
   int         resets_seen, steps_seen;
   int         errors = 0;
   int         checks = 0;
   int         tests = 0;
   int         cycles = 0;

   lwc_api_top #(.rc_last(RC_LAST)) i_lwc_api_top (
      .clk, .rst, .pdi, .pdi_valid, .pdi_ready, .pdo, .pdo_valid, .pdo_ready,
      .pdo_last, .core_ctrl, .core_din, .core_dout
   );

   // core model answers all zeros for a good tag
   assign core_dout = zero_tag ? '0 : core_din ^ CORE_MASK;

   always #(HALF) clk = ~clk;

   always @(negedge clk)
      pdo_ready <= stall_on ? ($urandom_range(3) != 0) : 1'b1;

   function automatic rc_t lfsr_next(input rc_t r);
      return {r[4:0], ~(r[5] ^ r[4])};
   endfunction

   function automatic int byte_count(input int len, input int idx);
      int r;
      r = len - 4 * idx;
      return (r <= 0) ? 0 : ((r >= 4) ? 4 : r);
   endfunction

   function automatic lwc_word_t keep_mask(input int n);
      return {{8{n > 0}}, {8{n > 1}}, {8{n > 2}}, {8{n > 3}}};
   endfunction

   function automatic byte_mask_t enables(input int n);
      return {n > 0, n > 1, n > 2, n > 3};
   endfunction

   // every segment in these tests carries the last flag
   function automatic domain_t block_domain(input int rem, input logic is_ad);
      if (rem < 16)
         return is_ad ? AD_PADDED : MSG_PADDED;
      else if (rem == 16)
         return is_ad ? AD_FINAL : MSG_FINAL;
      return is_ad ? AD_NORMAL : MSG_NORMAL;
   endfunction

   // word idx of a segment as the core should see it
   function automatic lwc_word_t padded_word(input lwc_word_t w, input int len, input int idx);
      lwc_word_t out;
      int rem;
      rem = len - 16 * (idx / 4);
      out = w & keep_mask(byte_count(len, idx));
      if (idx % 4 == 3 && rem < 16)
         out[3:0] = rem[3:0];
      return out;
   endfunction

   // expected pdo stream of one instruction
   function automatic void build_expected(input logic dec, input int msg_len,
                                          input logic good_tag);
      pdo_exp_t e;
      seg_len_t ml;
      int n;
      e = '0;
      ml = msg_len;
      e.word = {dec ? OP_PLAIN : OP_CIPHER, 1'b1, 1'b0, 1'b1, dec, 8'h00, ml};
      exp_q.push_back(e);
      for (int i = 0; 4 * i < msg_len; i++) begin
         n = byte_count(msg_len, i);
         e.word = (msg_w[i] ^ CORE_MASK) & keep_mask(n);
         e.mask = dec ? enables(n) : 4'h0;
         exp_q.push_back(e);
      end
      e.mask = 4'h0;
      if (!dec) begin
         e.word = {OP_TAG, 4'h3, 8'h00, 16'd16};
         exp_q.push_back(e);
         e.word = CORE_MASK;  // core answer to the zero words
         repeat (4)
            exp_q.push_back(e);
      end
      e.word = {(dec && !good_tag) ? OP_FAILURE : OP_SUCCESS, 28'h0};
      e.last = 1'b1;
      exp_q.push_back(e);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic send_word(input lwc_word_t w);
      logic taken;
      taken = 1'b0;
      while ($urandom_range(3) == 0)
         @(negedge clk);
      pdi = w;
      pdi_valid = 1'b1;
      while (!taken) begin
         #(HALF / 2);
         taken = pdi_ready;
         @(negedge clk);
      end
      pdi_valid = 1'b0;
   endtask

   // pdo compare, core loads and round sequencing
   always begin
      @(negedge clk);
      #(HALF / 2);
      if (!rst) begin
         if (pdo_valid && pdo_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("pdo word %h arrived when no word was expected", pdo);
            end else begin
               got_exp = exp_q.pop_front();
               check_value("pdo", pdo, got_exp.word);
               check_value("pdo_last", pdo_last, got_exp.last);
               check_value("dec_mask", core_ctrl.dec_mask, got_exp.mask);
            end
         end
         if (core_ctrl.state_load)
            load_q.push_back(core_din);
         if (core_ctrl.nonce_load)
            nonce_q.push_back(core_din);
         if (core_ctrl.ctr_reset)
            resets_seen++;
         if (core_ctrl.ctr_step)
            steps_seen++;
         if (core_ctrl.round_step) begin
            if (!in_run) begin  // first round of a run
               in_run = 1'b1;
               run_len = 0;
               exp_rc = RC_FIRST;
               dom_q.push_back(core_ctrl.domain);
            end
            check_value("rc", core_ctrl.rc, exp_rc);
            exp_rc = lfsr_next(exp_rc);
            run_len++;
         end else if (in_run) begin
            in_run = 1'b0;
            check_value("round_step cycles", run_len, rounds);
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > timeout_limit) begin
         $display("run timed out after %0d cycles without finishing the tests", cycles);
         $display("sim failed");
         $finish;
      end
   end

   task automatic run_aead(input string name, input logic dec, input int ad_len,
                           input int msg_len, input logic good_tag, input logic stall);
      int errs_before;
      int n_ad;
      int n_msg;
      seg_len_t ad_l;
      seg_len_t msg_l;
      logic [3:0] msg_flags;
      errs_before = errors;
      stall_on = stall;
      ad_l = ad_len;
      msg_l = msg_len;
      msg_flags = {3'b101, (msg_len % 16) != 0};
      n_ad = (ad_len + 15) / 16;
      n_msg = (msg_len + 15) / 16;
      ad_w.delete();
      msg_w.delete();
      nonce_w.delete();
      load_q.delete();
      nonce_q.delete();
      dom_q.delete();
      dom_exp.delete();
      resets_seen = 0;
      steps_seen = 0;
      for (int k = 0; 4 * k < ad_len; k++)
         ad_w.push_back($urandom);
      for (int k = 0; 4 * k < msg_len; k++)
         msg_w.push_back($urandom);
      repeat (4)
         nonce_w.push_back($urandom);
      build_expected(dec, msg_len, good_tag);
      for (int k = 0; k < n_ad; k++)
         dom_exp.push_back(block_domain(ad_len - 16 * k, 1'b1));
      dom_exp.push_back(n_ad > 0 ? dom_exp[n_ad - 1] : AD_PADDED);  // nonce run
      for (int k = 0; k < n_msg; k++)
         dom_exp.push_back(block_domain(msg_len - 16 * k, 1'b0));

      send_word({dec ? OP_DEC : OP_ENC, 28'h0});
      if (ad_len > 0) begin
         send_word({OP_AD, 4'b0010, 8'h00, ad_l});
         foreach (ad_w[i])
            send_word(ad_w[i]);
      end
      send_word({OP_NPUB, 4'b0010, 8'h00, 16'd16});
      foreach (nonce_w[i])
         send_word(nonce_w[i]);
      send_word({dec ? OP_CIPHER : OP_PLAIN, msg_flags, 8'h00, msg_l});
      foreach (msg_w[i])
         send_word(msg_w[i]);
      if (dec) begin
         send_word({OP_TAG, 4'b0011, 8'h00, 16'd16});
         zero_tag = good_tag;
         repeat (4)
            send_word($urandom | 32'h1);  // never equal to the core mask
      end
      while (exp_q.size() > 0)
         @(negedge clk);
      zero_tag = 1'b0;
      @(negedge clk);

      if (load_q.size() < 4 * (n_ad + n_msg)) begin
         errors++;
         $display("core took %0d words, at least %0d were due", load_q.size(),
                  4 * (n_ad + n_msg));
      end else begin
         for (int k = 0; k < 4 * n_ad; k++)
            check_value("core_din", load_q[k],
                        padded_word(k < ad_w.size() ? ad_w[k] : '0, ad_len, k));
         for (int k = 0; k < 4 * n_msg; k++)
            check_value("core_din", load_q[4 * n_ad + k],
                        padded_word(k < msg_w.size() ? msg_w[k] : '0, msg_len, k));
      end
      if (nonce_q.size() != 4) begin
         errors++;
         $display("core took %0d nonce words where 4 were due", nonce_q.size());
      end else begin
         foreach (nonce_w[k])
            check_value("core_din", nonce_q[k], nonce_w[k]);
      end
      check_value("ctr_reset pulses", resets_seen, 1);
      check_value("ctr_step pulses", steps_seen, n_ad + n_msg);
      if (dom_q.size() != dom_exp.size()) begin
         errors++;
         $display("saw %0d core runs where %0d were due", dom_q.size(), dom_exp.size());
      end else begin
         foreach (dom_exp[k])
            check_value("domain", dom_q[k], dom_exp[k]);
      end
      tests++;
      $display("%s: %s, %0d errors", name, (errors == errs_before) ? "ok" : "wrong",
               errors - errs_before);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      pdi = '0;
      pdi_valid = 1'b0;
      pdo_ready = 1'b0;
      zero_tag = 1'b0;
      stall_on = 1'b0;
      in_run = 1'b0;
      resets_seen = 0;
      steps_seen = 0;
      seed = 10;
      void'($urandom(seed));
      rounds = 0;
      exp_rc = RC_FIRST;
      do begin  // R steps from the first to the last constant
         exp_rc = lfsr_next(exp_rc);
         rounds++;
      end while (exp_rc != RC_LAST);
      timeout_limit = NUM_RUNS * (rounds + BLOCK_SLACK) + NUM_TESTS * TEST_SLACK + 20;

      repeat (9)
         @(negedge clk);
      #(HALF / 2);
      check_value("pdi_ready", pdi_ready, 1'b0);
      check_value("pdo_valid", pdo_valid, 1'b0);
      check_value("pdo_last", pdo_last, 1'b0);
      check_value("core_ctrl strobes", {core_ctrl.state_load, core_ctrl.nonce_load,
                  core_ctrl.ctr_reset, core_ctrl.ctr_step, core_ctrl.round_step}, 5'h0);
      $display("reset: %s", (errors == 0) ? "ok" : "wrong");
      @(negedge clk);
      rst = 1'b0;

      run_aead("enc_full", 1'b0, 16, 32, 1'b0, 1'b1);
      run_aead("dec_partial", 1'b1, 16, 6, 1'b1, 1'b0);
      run_aead("ad_padded", 1'b0, 5, 16, 1'b0, 1'b0);
      run_aead("round_seq", 1'b0, 32, 20, 1'b0, 1'b1);
      run_aead("dec_bad_tag", 1'b1, 16, 16, 1'b0, 1'b1);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== hdl/api_ctrl.sv ====
`timescale 1ns/100ps

module api_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  lwc_pkg::lwc_word_t   pdi,
   input  logic                 pdi_valid,
   input  logic                 pdo_ready,
   input  lwc_pkg::lwc_word_t   core_dout,
   input  core_pkg::rc_t        rc,
   input  logic                 word_last,
   input  logic                 run_done,
   input  logic                 seg_empty,
   input  logic                 seg_partial_next,
   input  logic                 seg_final,
   input  logic [2:0]           word_bytes,
   input  core_pkg::byte_mask_t byte_mask,
   output logic                 pdi_ready,
   output logic                 pdo_valid,
   output logic                 pdo_last,
   output lwc_pkg::pdo_sel_t    pdo_sel,
   output logic                 ctr_step,
   output logic                 ctr_clear,
   output logic                 hdr_load,
   output logic                 block_done,
   output logic                 pad_word,
   output logic                 dec,
   output logic                 mismatch,
   output core_pkg::core_ctrl_t core_ctrl
);
   import lwc_pkg::*;
   import core_pkg::*;

   typedef enum logic [3:0] {
      IDLE, AD_HEADER, AD_STORE, RUN_AD, NONCE_HEADER, NONCE_STORE, RUN_NONCE,
      MSG_HEADER, MSG_STORE, RUN_MSG, TAG_OUT_HEADER, TAG_OUT, TAG_IN_HEADER,
      TAG_IN, STATUS
   } stage_t;

   stage_t   stage, stage_n;
   seg_hdr_t hdr;
   domain_t  dom, dom_n, nonce_dom, nonce_dom_n;
   domain_t  ad_dom, msg_dom;
   logic     dec_n, mismatch_n, move;

   assign hdr = pdi;

   assign ad_dom  = seg_partial_next ? AD_PADDED : (seg_final ? AD_FINAL : AD_NORMAL);
   assign msg_dom = seg_partial_next ? MSG_PADDED : (seg_final ? MSG_FINAL : MSG_NORMAL);

   always_ff @(posedge clk) begin
      if (rst) begin
         stage     <= IDLE;
         dec       <= 1'b0;
         mismatch  <= 1'b0;
         dom       <= AD_NORMAL;
         nonce_dom <= AD_PADDED;
      end else begin
         stage     <= stage_n;
         dec       <= dec_n;
         mismatch  <= mismatch_n;
         dom       <= dom_n;
         nonce_dom <= nonce_dom_n;
      end
   end

   always_comb begin
      stage_n     = stage;
      dec_n       = dec;
      mismatch_n  = mismatch;
      dom_n       = dom;
      nonce_dom_n = nonce_dom;
      pdi_ready   = 1'b0;
      pdo_valid   = 1'b0;
      pdo_last    = 1'b0;
      pdo_sel     = PDO_DATA;
      ctr_step    = 1'b0;
      ctr_clear   = 1'b0;
      hdr_load    = 1'b0;
      block_done  = 1'b0;
      pad_word    = 1'b0;
      move        = 1'b0;
      core_ctrl    = '0;
      core_ctrl.rc = rc;
      case (stage)
         IDLE: begin
            pdi_ready = !rst;
            if (pdi_valid && (hdr.opcode == OP_ENC || hdr.opcode == OP_DEC)) begin
               dec_n       = (hdr.opcode == OP_DEC);
               mismatch_n  = 1'b0;
               nonce_dom_n = AD_PADDED;  // no AD at all
               core_ctrl.ctr_reset = 1'b1;
               stage_n     = AD_HEADER;
            end
         end
         AD_HEADER: begin
            pdi_ready = 1'b1;
            if (pdi_valid && hdr.opcode == OP_AD) begin
               hdr_load = 1'b1;
               stage_n  = AD_STORE;
            end else if (pdi_valid && hdr.opcode == OP_NPUB) begin
               hdr_load = 1'b1;
               stage_n  = NONCE_STORE;
            end
         end
         AD_STORE: begin
            pad_word  = (word_bytes == 3'd0);
            pdi_ready = !pad_word;
            move      = pad_word || pdi_valid;
            if (move) begin
               core_ctrl.state_load = 1'b1;
               if (word_last) begin
                  ctr_clear   = 1'b1;
                  block_done  = 1'b1;
                  core_ctrl.ctr_step = 1'b1;
                  dom_n       = ad_dom;
                  nonce_dom_n = ad_dom;
                  stage_n     = RUN_AD;
               end else begin
                  ctr_step = 1'b1;
               end
            end
         end
         NONCE_HEADER: begin
            pdi_ready = 1'b1;
            if (pdi_valid && hdr.opcode == OP_NPUB) begin
               hdr_load = 1'b1;
               stage_n  = NONCE_STORE;
            end
         end
         NONCE_STORE: begin
            pdi_ready = 1'b1;
            if (pdi_valid) begin
               core_ctrl.nonce_load = 1'b1;
               if (word_last) begin
                  ctr_clear = 1'b1;
                  dom_n     = nonce_dom;
                  stage_n   = RUN_NONCE;
               end else begin
                  ctr_step = 1'b1;
               end
            end
         end
         MSG_HEADER: begin
            // header goes straight through to pdo
            pdo_sel   = PDO_MSG_HDR;
            pdi_ready = pdo_ready;
            pdo_valid = pdi_valid;
            if (pdi_valid && pdo_ready) begin
               hdr_load = 1'b1;
               if (hdr.length != '0)
                  stage_n = MSG_STORE;
               else if (hdr.flags[1])
                  stage_n = dec ? TAG_IN_HEADER : TAG_OUT_HEADER;
            end
         end
         MSG_STORE: begin
            pad_word = (word_bytes == 3'd0);
            if (pad_word) begin
               move = 1'b1;
            end else begin
               pdi_ready = pdo_ready;
               pdo_valid = pdi_valid;
               move      = pdi_valid && pdo_ready;
            end
            if (move) begin
               core_ctrl.state_load = 1'b1;
               core_ctrl.dec_mask   = pad_word ? '0 : byte_mask;
               if (word_last) begin
                  ctr_clear  = 1'b1;
                  block_done = 1'b1;
                  core_ctrl.ctr_step = 1'b1;
                  dom_n      = msg_dom;
                  stage_n    = RUN_MSG;
               end else begin
                  ctr_step = 1'b1;
               end
            end
         end
         RUN_AD, RUN_NONCE, RUN_MSG: begin
            core_ctrl.round_step = 1'b1;
            core_ctrl.domain     = dom;
            if (!run_done) begin
               ctr_step = 1'b1;
            end else begin
               ctr_clear = 1'b1;
               if (stage == RUN_NONCE)
                  stage_n = MSG_HEADER;
               else if (stage == RUN_AD)
                  stage_n = !seg_empty ? AD_STORE : (seg_final ? NONCE_HEADER : AD_HEADER);
               else if (!seg_empty)
                  stage_n = MSG_STORE;
               else if (!seg_final)
                  stage_n = MSG_HEADER;
               else
                  stage_n = dec ? TAG_IN_HEADER : TAG_OUT_HEADER;
            end
         end
         TAG_OUT_HEADER: begin
            pdo_sel   = PDO_TAG_HDR;
            pdo_valid = 1'b1;
            if (pdo_ready)
               stage_n = TAG_OUT;
         end
         TAG_OUT: begin
            pdo_sel   = PDO_TAG;
            pdo_valid = 1'b1;
            pad_word  = 1'b1;  // state shifts out against zeros
            if (pdo_ready) begin
               core_ctrl.state_load = 1'b1;
               if (word_last) begin
                  ctr_clear = 1'b1;
                  stage_n   = STATUS;
               end else begin
                  ctr_step = 1'b1;
               end
            end
         end
         TAG_IN_HEADER: begin
            pdi_ready = 1'b1;
            if (pdi_valid && hdr.opcode == OP_TAG) begin
               hdr_load = 1'b1;
               stage_n  = TAG_IN;
            end
         end
         TAG_IN: begin
            pdi_ready = 1'b1;
            if (pdi_valid) begin
               core_ctrl.state_load = 1'b1;
               if (core_dout != '0)
                  mismatch_n = 1'b1;
               if (word_last) begin
                  ctr_clear = 1'b1;
                  stage_n   = STATUS;
               end else begin
                  ctr_step = 1'b1;
               end
            end
         end
         STATUS: begin
            pdo_sel   = PDO_STATUS;
            pdo_valid = 1'b1;
            pdo_last  = 1'b1;
            if (pdo_ready)
               stage_n = IDLE;
         end
         default: stage_n = IDLE;
      endcase
   end

   a_pdo_hold: assert property (@(posedge clk) disable iff (rst)
      pdo_valid && !pdo_ready |=> pdo_valid);

   // every run starts from the first constant
   a_run_from_first: assert property (@(posedge clk) disable iff (rst)
      core_ctrl.round_step && !$past(core_ctrl.round_step) |-> rc == RC_FIRST);

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

   typedef logic [5:0] rc_t;
   typedef logic [7:0] domain_t;
   typedef logic [3:0] byte_mask_t;

   localparam rc_t RC_FIRST        = 6'h01;
   localparam rc_t RC_LAST_DEFAULT = 6'h1A;

   // domain separation bytes
   localparam domain_t AD_NORMAL  = 8'd8;
   localparam domain_t AD_FINAL   = 8'd24;
   localparam domain_t AD_PADDED  = 8'd26;
   localparam domain_t MSG_NORMAL = 8'd4;
   localparam domain_t MSG_FINAL  = 8'd20;
   localparam domain_t MSG_PADDED = 8'd21;

   typedef struct packed {
      logic       state_load;  // core_din into state
      logic       nonce_load;  // core_din into tweak lane
      logic       ctr_reset;
      logic       ctr_step;    // block counter
      logic       round_step;
      domain_t    domain;
      rc_t        rc;
      byte_mask_t dec_mask;
   } core_ctrl_t;

endpackage

// ==== hdl/lwc_api_top.sv ====
`timescale 1ns/100ps

module lwc_api_top #(
   parameter core_pkg::rc_t rc_last = core_pkg::RC_LAST_DEFAULT
) (
   input  logic                 clk,
   input  logic                 rst,
   input  lwc_pkg::lwc_word_t   pdi,
   input  logic                 pdi_valid,
   output logic                 pdi_ready,
   output lwc_pkg::lwc_word_t   pdo,
   output logic                 pdo_valid,
   input  logic                 pdo_ready,
   output logic                 pdo_last,
   output core_pkg::core_ctrl_t core_ctrl,
   output lwc_pkg::lwc_word_t   core_din,
   input  lwc_pkg::lwc_word_t   core_dout
);
   import lwc_pkg::*;
   import core_pkg::*;

   rc_t        rc;
   logic       word_last, run_done, ctr_step, ctr_clear;
   logic       hdr_load, block_done, pad_word;
   logic       seg_empty, seg_partial_next, seg_final;
   logic [2:0] word_bytes;
   logic       dec, mismatch;
   pdo_sel_t   pdo_sel;
   byte_mask_t dec_mask;
   seg_hdr_t   hdr;

   assign hdr = pdi;  // header view of the input word

   api_ctrl i_api_ctrl (
      .clk, .rst, .pdi, .pdi_valid, .pdo_ready, .core_dout,
      .rc, .word_last, .run_done,
      .seg_empty, .seg_partial_next, .seg_final, .word_bytes,
      .byte_mask (dec_mask),
      .pdi_ready, .pdo_valid, .pdo_last, .pdo_sel,
      .ctr_step, .ctr_clear, .hdr_load, .block_done, .pad_word,
      .dec, .mismatch, .core_ctrl
   );

   round_counter #(.rc_last(rc_last)) i_round_counter (
      .clk, .rst, .step (ctr_step), .clear (ctr_clear),
      .rc, .word_last, .run_done
   );

   segment_tracker i_segment_tracker (
      .clk, .rst, .hdr_load, .hdr, .block_done, .pad_word, .pdi, .rc,
      .seg_empty, .seg_partial_next, .seg_final, .word_bytes, .core_din
   );

   pdo_formatter i_pdo_formatter (
      .pdo_sel, .hdr, .dec, .core_dout, .word_bytes, .mismatch,
      .pdo, .dec_mask
   );

endmodule

// ==== hdl/lwc_pkg.sv ====
package lwc_pkg;

   typedef logic [31:0] lwc_word_t;
   typedef logic [15:0] seg_len_t;
   typedef logic [3:0]  opcode_t;

   // instructions
   localparam opcode_t OP_ENC     = 4'd2;
   localparam opcode_t OP_DEC     = 4'd3;

   // segment types
   localparam opcode_t OP_AD      = 4'd1;
   localparam opcode_t OP_PLAIN   = 4'd4;
   localparam opcode_t OP_CIPHER  = 4'd5;
   localparam opcode_t OP_TAG     = 4'd8;
   localparam opcode_t OP_NPUB    = 4'd13;

   // status
   localparam opcode_t OP_SUCCESS = 4'd14;
   localparam opcode_t OP_FAILURE = 4'd15;

   typedef struct packed {
      opcode_t    opcode;
      logic [3:0] flags;  // 3 eoi, 1 last, 0 partial
      logic [7:0] reserved;
      seg_len_t   length;
   } seg_hdr_t;

   // pdo word source
   typedef logic [2:0] pdo_sel_t;
   localparam pdo_sel_t PDO_MSG_HDR = 3'd0;
   localparam pdo_sel_t PDO_DATA    = 3'd1;
   localparam pdo_sel_t PDO_TAG_HDR = 3'd2;
   localparam pdo_sel_t PDO_TAG     = 3'd3;
   localparam pdo_sel_t PDO_STATUS  = 3'd4;

endpackage

// ==== hdl/pdo_formatter.sv ====
`timescale 1ns/100ps

module pdo_formatter (
   input  lwc_pkg::pdo_sel_t    pdo_sel,
   input  lwc_pkg::seg_hdr_t    hdr,
   input  logic                 dec,
   input  lwc_pkg::lwc_word_t   core_dout,
   input  logic [2:0]           word_bytes,
   input  logic                 mismatch,
   output lwc_pkg::lwc_word_t   pdo,
   output core_pkg::byte_mask_t dec_mask
);
   import lwc_pkg::*;
   import core_pkg::*;

   byte_mask_t mask;
   seg_hdr_t   msg_hdr;

   always_comb begin
      case (word_bytes)
         3'd0:    mask = 4'b0000;
         3'd1:    mask = 4'b1000;
         3'd2:    mask = 4'b1100;
         3'd3:    mask = 4'b1110;
         default: mask = 4'b1111;
      endcase
   end

   assign dec_mask = dec ? mask : '0;

   always_comb begin
      msg_hdr        = hdr;
      msg_hdr.opcode = dec ? OP_PLAIN : OP_CIPHER;
      // last flag lands in bit 0 too when decrypting
      msg_hdr.flags  = {hdr.flags[3], 1'b0, hdr.flags[1], dec & hdr.flags[1]};
   end

   always_comb begin
      case (pdo_sel)
         PDO_MSG_HDR: pdo = msg_hdr;
         PDO_DATA: begin
            for (int b = 0; b < 4; b++)
               pdo[8*b +: 8] = mask[b] ? core_dout[8*b +: 8] : 8'h00;
         end
         PDO_TAG_HDR: pdo = {OP_TAG, 4'h3, 8'h00, 16'd16};
         PDO_TAG:     pdo = core_dout;
         PDO_STATUS:  pdo = {mismatch ? OP_FAILURE : OP_SUCCESS, 28'h0};
         default:     pdo = '0;
      endcase
   end

endmodule

// ==== hdl/round_counter.sv ====
`timescale 1ns/100ps

module round_counter #(
   parameter core_pkg::rc_t rc_last = core_pkg::RC_LAST_DEFAULT
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          step,
   input  logic          clear,
   output core_pkg::rc_t rc,
   output logic          word_last,
   output logic          run_done
);
   import core_pkg::*;

   rc_t rc_next;

   // shift left, feed back inverted xor of the top bits
   assign rc_next = {rc[4:0], ~(rc[5] ^ rc[4])};

   always_ff @(posedge clk) begin
      if (rst || clear)
         rc <= RC_FIRST;
      else if (step)
         rc <= rc_next;
   end

   assign word_last = (rc == 6'h0F);
   assign run_done  = (rc_next == rc_last);

   a_rc_nonzero: assert property (@(posedge clk) disable iff (rst) rc != '0);

endmodule

// ==== hdl/segment_tracker.sv ====
`timescale 1ns/100ps

module segment_tracker (
   input  logic               clk,
   input  logic               rst,
   input  logic               hdr_load,
   input  lwc_pkg::seg_hdr_t  hdr,
   input  logic               block_done,
   input  logic               pad_word,
   input  lwc_pkg::lwc_word_t pdi,
   input  core_pkg::rc_t      rc,
   output logic               seg_empty,
   output logic               seg_partial_next,
   output logic               seg_final,
   output logic [2:0]         word_bytes,
   output lwc_pkg::lwc_word_t core_din
);
   import lwc_pkg::*;

   seg_len_t   len, offset;
   logic [3:0] flags;
   logic [1:0] idx;
   lwc_word_t  data, masked;

   always_ff @(posedge clk) begin
      if (rst) begin
         len   <= '0;
         flags <= '0;
      end else if (hdr_load) begin
         len   <= hdr.length;
         flags <= hdr.flags;
      end else if (block_done) begin
         len <= (len > 16'd16) ? len - 16'd16 : '0;
      end
   end

   assign seg_empty        = (len == '0);
   assign seg_partial_next = (len < 16'd16);
   assign seg_final        = flags[1] && (len <= 16'd16);

   // word index within the block from rc
   always_comb begin
      case (rc)
         6'h01:   idx = 2'd0;
         6'h03:   idx = 2'd1;
         6'h07:   idx = 2'd2;
         default: idx = 2'd3;
      endcase
   end

   assign offset = {12'd0, idx, 2'b00};

   always_comb begin
      if (len <= offset)
         word_bytes = 3'd0;
      else if (len - offset >= 16'd4)
         word_bytes = 3'd4;
      else
         word_bytes = len[2:0] - offset[2:0];
   end

   assign data = pad_word ? '0 : pdi;

   always_comb begin
      for (int b = 0; b < 4; b++)
         masked[31 - 8*b -: 8] = (b < word_bytes) ? data[31 - 8*b -: 8] : 8'h00;
   end

   // 0F word of a short block carries the byte count
   assign core_din = (idx == 2'd3 && seg_partial_next) ? {masked[31:4], len[3:0]} : masked;

endmodule

// ==== verilog.f ====
hdl/lwc_pkg.sv
hdl/core_pkg.sv
hdl/round_counter.sv
hdl/segment_tracker.sv
hdl/pdo_formatter.sv
hdl/api_ctrl.sv
hdl/lwc_api_top.sv
bench/tb_lwc_api.sv
